// File: src/acia_pkg.sv
// ACIA shared constants and types

package acia_pkg;

	localparam int CLK_FREQ = 32768;          // system clock in Hz
	localparam int SYM_RATE = 1200;           // serial bit rate
	localparam int SYM_CNT  = CLK_FREQ / SYM_RATE;  // clocks per bit
	localparam int SCW      = $clog2(SYM_CNT);      // rate counter width

	// status byte bit positions
	localparam int ST_RXF = 0;                // receive full
	localparam int ST_TXE = 1;                // transmit empty
	localparam int ST_FE  = 4;                // framing error
	localparam int ST_OVR = 5;                // overrun, shares framing error
	localparam int ST_IRQ = 7;                // interrupt pending

	typedef enum logic {
		REG_CTRL_STAT = 1'b0,                 // control on write, status on read
		REG_DATA      = 1'b1                  // tx data on write, rx data on read
	} reg_sel_t;

	typedef enum logic [1:0] {
		RX_IDLE, RX_START, RX_DATA, RX_STOP
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE, TX_START, TX_DATA, TX_STOP
	} tx_state_t;

	typedef enum logic [2:0] {
		EC_POLL, EC_WAIT_STAT, EC_READ, EC_WAIT_DATA, EC_WRITE
	} echo_state_t;

endpackage

// File: src/acia_rx.sv
// ACIA serial receiver

module acia_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_serial,
	output logic [7:0] rx_dat,
	output logic       rx_stb,
	output logic       rx_err
);
	import acia_pkg::*;

	logic [1:0]     sync;                     // two flop synchroniser
	logic           line;                     // synchronised line
	logic           line_d;                   // for start edge detect
	logic [SCW-1:0] cnt;                      // rate counter
	logic [2:0]     bit_cnt;                  // data bit index
	logic [7:0]     shreg;                    // incoming data, lsb first
	logic           tick;
	rx_state_t      state;

	assign line = sync[1];
	assign tick = (cnt == '0);                // mid-bit sample point

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sync    <= 2'b11;                 // line idles high
			line_d  <= 1'b1;
			state   <= RX_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			rx_stb  <= 1'b0;
			rx_err  <= 1'b0;
		end
		else
		begin
			sync   <= {sync[0], rx_serial};
			line_d <= line;
			rx_stb <= 1'b0;                   // single cycle strobe
			case (state)
				RX_IDLE:
					if (line_d & ~line)       // falling start edge
					begin
						state <= RX_START;
						cnt   <= SCW'(SYM_CNT / 2 - 1);  // half a bit
					end
				RX_START:
					if (!tick)
						cnt <= cnt - 1'b1;
					else if (!line)           // start bit still low, genuine
					begin
						state   <= RX_DATA;
						cnt     <= SCW'(SYM_CNT - 1);
						bit_cnt <= '0;
					end
					else
						state <= RX_IDLE;     // glitch, ignore
				RX_DATA:
					if (!tick)
						cnt <= cnt - 1'b1;
					else
					begin
						cnt     <= SCW'(SYM_CNT - 1);
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				RX_STOP:
					if (!tick)
						cnt <= cnt - 1'b1;
					else
					begin
						rx_stb <= 1'b1;
						rx_err <= ~line;      // low stop bit is a framing error
						state  <= RX_IDLE;
					end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// data path
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && tick)
			shreg <= {line, shreg[7:1]};      // shift in lsb first
		if (state == RX_STOP && tick)
			rx_dat <= shreg;                  // hold byte for the cpu side
	end

endmodule

// File: src/acia_tx.sv
// ACIA serial transmitter, 8N1

module acia_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic       tx_start,
	input  logic [7:0] tx_dat,
	output logic       tx_serial,
	output logic       tx_busy
);
	import acia_pkg::*;

	logic [9:0]     frame;                    // stop, data, start
	logic [SCW-1:0] cnt;                      // rate counter
	logic [2:0]     bit_cnt;                  // data bit index
	logic           tick;
	tx_state_t      state;

	assign tick      = (cnt == '0);           // end of current bit
	assign tx_serial = frame[0];              // registered, no glitches
	assign tx_busy   = (state != TX_IDLE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			frame   <= '1;                    // line held at mark
			state   <= TX_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
					if (tx_start)             // writes while busy are dropped
					begin
						frame <= {1'b1, tx_dat, 1'b0};
						cnt   <= SCW'(SYM_CNT - 1);
						state <= TX_START;
					end
				TX_START:
					if (!tick)
						cnt <= cnt - 1'b1;
					else
					begin
						frame   <= {1'b1, frame[9:1]};  // first data bit
						cnt     <= SCW'(SYM_CNT - 1);
						bit_cnt <= '0;
						state   <= TX_DATA;
					end
				TX_DATA:
					if (!tick)
						cnt <= cnt - 1'b1;
					else
					begin
						frame   <= {1'b1, frame[9:1]};
						cnt     <= SCW'(SYM_CNT - 1);
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= TX_STOP;  // stop bit now on the line
					end
				TX_STOP:
					if (!tick)
						cnt <= cnt - 1'b1;
					else
						state <= TX_IDLE;
				default:
					state <= TX_IDLE;
			endcase
		end
	end

endmodule

// File: src/acia.sv
// MC6850 style ACIA core

module acia (
	input  logic               clk,
	input  logic               rst,
	input  logic               cs,
	input  logic               we,
	input  acia_pkg::reg_sel_t rs,
	input  logic               rx,
	input  logic [7:0]         din,
	output logic [7:0]         dout,
	output logic               tx,
	output logic               irq
);
	import acia_pkg::*;

	logic [1:0] cdiv_sel;                     // counter divide, 11 is master reset
	logic [1:0] tx_ctrl;                      // 01 enables tx interrupt
	logic       rx_ie;                        // rx interrupt enable
	logic       acia_rst;
	logic       wr_ctrl;
	logic       wr_data;
	logic       rd_data;
	logic [7:0] rx_dat;
	logic       rx_stb;
	logic       rx_err;
	logic       tx_busy;
	logic       tx_busy_d;
	logic       txe;
	logic       rxf;
	logic [7:0] status;

	assign wr_ctrl = cs & we & (rs == REG_CTRL_STAT);
	assign wr_data = cs & we & (rs == REG_DATA);  // also starts the transmitter
	assign rd_data = cs & ~we & (rs == REG_DATA);

	// control register; word select bits 4:2 are accepted and ignored
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cdiv_sel <= 2'b00;
			tx_ctrl  <= 2'b00;
			rx_ie    <= 1'b0;
		end
		else if (wr_ctrl)
		begin
			cdiv_sel <= din[1:0];
			tx_ctrl  <= din[6:5];
			rx_ie    <= din[7];
		end
	end

	assign acia_rst = rst | (cdiv_sel == 2'b11);  // soft reset held until field changes

	// txe drops on a data write, returns once the frame is done
	always_ff @(posedge clk)
	begin
		if (acia_rst)
		begin
			txe       <= 1'b1;
			tx_busy_d <= 1'b0;
		end
		else
		begin
			tx_busy_d <= tx_busy;
			if (wr_data)
				txe <= 1'b0;
			else if (tx_busy_d & ~tx_busy)
				txe <= 1'b1;
		end
	end

	// rxf set by the receiver strobe, cleared by a data read
	always_ff @(posedge clk)
	begin
		if (acia_rst)
			rxf <= 1'b0;
		else if (rx_stb)
			rxf <= 1'b1;
		else if (rd_data)
			rxf <= 1'b0;
	end

	// status byte, cts and dcd report active low as always asserted
	always_comb
	begin
		status         = 8'h00;
		status[ST_RXF] = rxf;
		status[ST_TXE] = txe;
		status[ST_FE]  = rx_err;
		status[ST_OVR] = rx_err;              // overrun folded into framing
		status[ST_IRQ] = irq;
	end

	always_ff @(posedge clk)
	begin
		if (cs & ~we)
			dout <= (rs == REG_DATA) ? rx_dat : status;
	end

	assign irq = (rxf & rx_ie) | ((tx_ctrl == 2'b01) & txe);

	acia_rx u_rx (
		.clk       (clk),
		.rst       (acia_rst),
		.rx_serial (rx),
		.rx_dat    (rx_dat),
		.rx_stb    (rx_stb),
		.rx_err    (rx_err)
	);

	acia_tx u_tx (
		.clk       (clk),
		.rst       (acia_rst),
		.tx_start  (wr_data),
		.tx_dat    (din),
		.tx_serial (tx),
		.tx_busy   (tx_busy)
	);

endmodule

// File: src/bus_arbiter.sv
// Host / echo engine bus arbiter

module bus_arbiter (
	input  logic               clk,
	input  logic               rst,
	input  logic               host_cs,
	input  logic               host_we,
	input  acia_pkg::reg_sel_t host_rs,
	input  logic [7:0]         host_din,
	input  logic               eng_req,
	input  logic               eng_we,
	input  acia_pkg::reg_sel_t eng_rs,
	input  logic [7:0]         eng_din,
	output logic               eng_gnt,
	output logic               cs,
	output logic               we,
	output acia_pkg::reg_sel_t rs,
	output logic [7:0]         din,
	input  logic [7:0]         dout_in,
	output logic [7:0]         host_dout,
	output logic               host_rd_valid,
	output logic               eng_rd_valid
);
	import acia_pkg::*;

	logic rd_p1;                              // read issued to the ACIA this cycle
	logic own_p1;                             // owner of that read, 1 is the engine

	assign eng_gnt   = eng_req & ~host_cs;    // host always wins
	assign host_dout = dout_in;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cs            <= 1'b0;
			rd_p1         <= 1'b0;
			host_rd_valid <= 1'b0;
			eng_rd_valid  <= 1'b0;
		end
		else
		begin
			cs            <= host_cs | eng_req;
			rd_p1         <= host_cs ? ~host_we : (eng_req & ~eng_we);
			host_rd_valid <= rd_p1 & ~own_p1;  // lines up with registered dout
			eng_rd_valid  <= rd_p1 & own_p1;
		end
	end

	// winning access, qualified by cs
	always_ff @(posedge clk)
	begin
		we     <= host_cs ? host_we  : eng_we;
		rs     <= host_cs ? host_rs  : eng_rs;
		din    <= host_cs ? host_din : eng_din;
		own_p1 <= ~host_cs;
	end

endmodule

// File: src/echo_engine.sv
// Serial echo engine

module echo_engine (
	input  logic               clk,
	input  logic               rst,
	input  logic               echo_en,
	input  logic               eng_gnt,
	input  logic               eng_rd_valid,
	input  logic [7:0]         rd_data,
	output logic               eng_req,
	output logic               eng_we,
	output acia_pkg::reg_sel_t eng_rs,
	output logic [7:0]         eng_din
);
	import acia_pkg::*;

	echo_state_t state;
	logic [7:0]  byte_q;                      // byte being echoed

	// request held in the issuing states until granted
	assign eng_req = ((state == EC_POLL) & echo_en) | (state == EC_READ) | (state == EC_WRITE);
	assign eng_we  = (state == EC_WRITE);
	assign eng_rs  = (state == EC_POLL) ? REG_CTRL_STAT : REG_DATA;
	assign eng_din = byte_q;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= EC_POLL;
		else
		begin
			case (state)
				EC_POLL:
					if (eng_gnt)
						state <= EC_WAIT_STAT;
				EC_WAIT_STAT:
					if (eng_rd_valid)
						// need a byte in and room to send it
						state <= (rd_data[ST_RXF] & rd_data[ST_TXE]) ? EC_READ : EC_POLL;
				EC_READ:
					if (eng_gnt)
						state <= EC_WAIT_DATA;
				EC_WAIT_DATA:
					if (eng_rd_valid)
						state <= EC_WRITE;
				EC_WRITE:
					if (eng_gnt)
						state <= EC_POLL;
				default:
					state <= EC_POLL;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == EC_WAIT_DATA && eng_rd_valid)
			byte_q <= rd_data;
	end

endmodule

// File: src/acia_subsys.sv
// Serial port subsystem top

module acia_subsys (
	input  logic               clk,
	input  logic               rst,
	input  logic               echo_en,
	input  logic               host_cs,
	input  logic               host_we,
	input  acia_pkg::reg_sel_t host_rs,
	input  logic [7:0]         host_din,
	output logic [7:0]         host_dout,
	output logic               host_rd_valid,
	input  logic               rx,
	output logic               tx,
	output logic               irq
);
	import acia_pkg::*;

	logic       cs;                           // ACIA bus
	logic       we;
	reg_sel_t   rs;
	logic [7:0] din;
	logic [7:0] rd_data;                      // registered ACIA read data
	logic       eng_req;                      // echo engine bus
	logic       eng_we;
	reg_sel_t   eng_rs;
	logic [7:0] eng_din;
	logic       eng_gnt;
	logic       eng_rd_valid;

	bus_arbiter u_arb (
		.clk           (clk),
		.rst           (rst),
		.host_cs       (host_cs),
		.host_we       (host_we),
		.host_rs       (host_rs),
		.host_din      (host_din),
		.eng_req       (eng_req),
		.eng_we        (eng_we),
		.eng_rs        (eng_rs),
		.eng_din       (eng_din),
		.eng_gnt       (eng_gnt),
		.cs            (cs),
		.we            (we),
		.rs            (rs),
		.din           (din),
		.dout_in       (rd_data),
		.host_dout     (host_dout),
		.host_rd_valid (host_rd_valid),
		.eng_rd_valid  (eng_rd_valid)
	);

	echo_engine u_echo (
		.clk          (clk),
		.rst          (rst),
		.echo_en      (echo_en),
		.eng_gnt      (eng_gnt),
		.eng_rd_valid (eng_rd_valid),
		.rd_data      (rd_data),
		.eng_req      (eng_req),
		.eng_we       (eng_we),
		.eng_rs       (eng_rs),
		.eng_din      (eng_din)
	);

	acia u_acia (
		.clk  (clk),
		.rst  (rst),
		.cs   (cs),
		.we   (we),
		.rs   (rs),
		.rx   (rx),
		.din  (din),
		.dout (rd_data),
		.tx   (tx),
		.irq  (irq)
	);

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock and reset

module tb_clock_gen (
	output logic clk,
	output logic rst
);
	localparam int HALF_PERIOD = 5;           // 10 unit period

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (4) @(posedge clk);            // 4 cycles of reset
		rst <= 1'b0;
	end

endmodule

// File: verification/acia_properties.sv
// ACIA and arbiter assertions

module acia_properties (
	input logic       clk,
	input logic       rst,
	input logic       acia_rst,
	input logic       tx,
	input logic       cs,
	input logic       we,
	input logic       rs,
	input logic [7:0] din,
	input logic       eng_gnt,
	input logic       eng_we,
	input logic       eng_rs,
	input logic [7:0] eng_din,
	input logic       rx_stb
);

	// line must sit at mark once reset has been seen for a cycle
	a_tx_high_in_reset: assert property (@(posedge clk)
		(acia_rst && $past(acia_rst)) |-> tx)
		else $error("tx low while the ACIA is held in reset");

	// a granted engine access lands on the ACIA bus, not a host one
	a_gnt_to_bus: assert property (@(posedge clk) disable iff (rst)
		eng_gnt |=> (cs && we == $past(eng_we) && rs == $past(eng_rs)
			&& din == $past(eng_din)))
		else $error("granted engine access did not reach the ACIA bus");

	a_rx_stb_single: assert property (@(posedge clk) disable iff (rst)
		rx_stb |=> !rx_stb)
		else $error("receiver strobe held for two cycles");

endmodule

// File: verification/tb_acia_subsys.sv
// ACIA subsystem testbench

module tb_acia_subsys;
	import acia_pkg::*;

	localparam int N_ECHO     = 8;            // bytes in the echo run
	localparam int FRAME_CLKS = 10 * SYM_CNT;
	localparam int NUM_FRAMES = 16 + 2 * N_ECHO;  // rx plus tx frames, rounded up
	localparam int TIMEOUT    = NUM_FRAMES * FRAME_CLKS * 10 + 20000;

	logic       clk;
	logic       rst;
	logic       echo_en;
	logic       host_cs;
	logic       host_we;
	reg_sel_t   host_rs;
	logic [7:0] host_din;
	logic [7:0] host_dout;
	logic       host_rd_valid;
	logic       rx;
	logic       tx;
	logic       irq;

	integer     seed;
	int         checks;
	int         errors;
	logic [7:0] exp_q[$];                     // expected host read data
	string      msg_q[$];
	logic [7:0] tx_q[$];                      // bytes decoded off tx

	// reference model state
	logic       m_rxf;
	logic       m_txe;
	logic       m_err;
	logic       m_rx_ie;
	logic [1:0] m_tx_ctrl;

	tb_clock_gen u_clk (
		.clk (clk),
		.rst (rst)
	);

	acia_subsys UUT (
		.clk           (clk),
		.rst           (rst),
		.echo_en       (echo_en),
		.host_cs       (host_cs),
		.host_we       (host_we),
		.host_rs       (host_rs),
		.host_din      (host_din),
		.host_dout     (host_dout),
		.host_rd_valid (host_rd_valid),
		.rx            (rx),
		.tx            (tx),
		.irq           (irq)
	);

	bind acia_subsys acia_properties u_props (
		.clk      (clk),
		.rst      (rst),
		.acia_rst (u_acia.acia_rst),
		.tx       (tx),
		.cs       (cs),
		.we       (we),
		.rs       (rs),
		.din      (din),
		.eng_gnt  (eng_gnt),
		.eng_we   (eng_we),
		.eng_rs   (eng_rs),
		.eng_din  (eng_din),
		.rx_stb   (u_acia.rx_stb)
	);

	function automatic logic model_irq();
		return (m_rxf & m_rx_ie) | ((m_tx_ctrl == 2'b01) & m_txe);
	endfunction

	function automatic logic [7:0] expected_status(input logic rxf, input logic txe,
		input logic err, input logic irq_v);
		logic [7:0] s;
		s         = 8'h00;                    // placeholders read as zero
		s[ST_RXF] = rxf;
		s[ST_TXE] = txe;
		s[ST_FE]  = err;
		s[ST_OVR] = err;                      // overrun reported with framing
		s[ST_IRQ] = irq_v;
		return s;
	endfunction

	task automatic check_eq(input logic [7:0] got, input logic [7:0] exp, input string msg);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0t: %s, got %02h expected %02h", $time, msg, got, exp);
		end
	endtask

	task automatic host_write(input reg_sel_t r, input logic [7:0] d);
		@(posedge clk);
		host_cs  <= 1'b1;
		host_we  <= 1'b1;
		host_rs  <= r;
		host_din <= d;
		@(posedge clk);
		host_cs  <= 1'b0;
		host_we  <= 1'b0;
		@(posedge clk);                       // write lands in the ACIA
	endtask

	task automatic host_read(input reg_sel_t r, input logic [7:0] exp, input string msg);
		int waits;
		exp_q.push_back(exp);
		msg_q.push_back(msg);
		@(posedge clk);
		host_cs <= 1'b1;
		host_we <= 1'b0;
		host_rs <= r;
		@(posedge clk);
		host_cs <= 1'b0;
		waits = 0;
		while (exp_q.size() != 0 && waits < 8)  // compare process pops on valid
		begin
			@(posedge clk);
			waits++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("ERROR at %0t: no read response for '%s'", $time, msg);
			exp_q.delete();
			msg_q.delete();
		end
	endtask

	task automatic read_status(input string msg);
		host_read(REG_CTRL_STAT, expected_status(m_rxf, m_txe, m_err, model_irq()), msg);
	endtask

	task automatic check_irq(input string msg);
		@(negedge clk);
		check_eq({7'b0, irq}, {7'b0, model_irq()}, msg);
	endtask

	task automatic drive_bit(input logic v);
		@(posedge clk);
		rx <= v;
		repeat (SYM_CNT - 1) @(posedge clk);
	endtask

	// start, 8 data lsb first, stop, then one bit of idle
	task automatic send_frame(input logic [7:0] b, input logic bad_stop);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(~bad_stop);
		drive_bit(1'b1);
	endtask

	task automatic wait_tx_byte(output logic [7:0] b);
		int waits;
		waits = 0;
		while (tx_q.size() == 0 && waits < 2 * FRAME_CLKS)
		begin
			@(posedge clk);
			waits++;
		end
		if (tx_q.size() == 0)
		begin
			errors++;
			$display("ERROR at %0t: no frame appeared on tx", $time);
			b = 8'h00;
		end
		else
			b = tx_q.pop_front();
	endtask

	// serial monitor, samples mid bit
	initial
	begin : tx_monitor
		logic [7:0] b;
		int         i;
		@(negedge rst);
		forever
		begin
			@(negedge tx);
			repeat (SYM_CNT / 2) @(negedge clk);
			if (tx !== 1'b0)
			begin
				errors++;
				$display("ERROR at %0t: start bit on tx did not hold low", $time);
			end
			for (i = 0; i < 8; i++)
			begin
				repeat (SYM_CNT) @(negedge clk);
				b[i] = tx;
			end
			repeat (SYM_CNT) @(negedge clk);
			if (tx !== 1'b1)
			begin
				errors++;
				$display("ERROR at %0t: stop bit on tx was low", $time);
			end
			tx_q.push_back(b);
		end
	end

	always @(negedge clk)
	begin : compare_reads
		logic [7:0] exp_val;
		string      exp_msg;
		if (host_rd_valid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("ERROR at %0t: read data returned with no read pending", $time);
			end
			else
			begin
				exp_val = exp_q.pop_front();
				exp_msg = msg_q.pop_front();
				check_eq(host_dout, exp_val, exp_msg);
			end
		end
	end

	initial
	begin : watchdog
		#TIMEOUT;
		$display("ERROR: watchdog expired after %0d time units, run stalled", TIMEOUT);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Test failures found");
		$finish;
	end

	initial
	begin : main_seq
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] got;
		logic [7:0] sent_q[$];
		int         i;
		seed      = 32'h1fe3;
		checks    = 0;
		errors    = 0;
		echo_en   = 1'b0;
		host_cs   = 1'b0;
		host_we   = 1'b0;
		host_rs   = REG_CTRL_STAT;
		host_din  = 8'h00;
		rx        = 1'b1;                     // line idles high
		m_rxf     = 1'b0;
		m_txe     = 1'b1;
		m_err     = 1'b0;
		m_rx_ie   = 1'b0;
		m_tx_ctrl = 2'b00;
		@(negedge rst);
		@(posedge clk);
		read_status("status after reset");

		// host write goes out on tx
		b = 8'($random(seed));
		host_write(REG_DATA, b);
		m_txe = 1'b0;
		read_status("txe low during frame");
		wait_tx_byte(got);
		check_eq(got, b, "tx frame byte");
		repeat (SYM_CNT) @(posedge clk);      // rest of stop bit, txe latency
		m_txe = 1'b1;
		read_status("txe set after frame");

		// receive path
		b = 8'($random(seed));
		send_frame(b, 1'b0);
		m_rxf = 1'b1;
		read_status("rxf after frame");
		host_read(REG_DATA, b, "rx data");
		m_rxf = 1'b0;
		read_status("rxf cleared by data read");

		// framing error then recovery
		b = 8'($random(seed));
		send_frame(b, 1'b1);
		m_rxf = 1'b1;
		m_err = 1'b1;
		read_status("framing error set");
		host_read(REG_DATA, b, "rx data with low stop bit");
		m_rxf = 1'b0;
		c = 8'($random(seed));
		send_frame(c, 1'b0);
		m_rxf = 1'b1;
		m_err = 1'b0;
		read_status("framing error cleared by good frame");
		host_read(REG_DATA, c, "rx data after recovery");
		m_rxf = 1'b0;

		// rx interrupt
		host_write(REG_CTRL_STAT, 8'h80);
		m_rx_ie = 1'b1;
		check_irq("irq low with rxf clear");
		b = 8'($random(seed));
		send_frame(b, 1'b0);
		m_rxf = 1'b1;
		check_irq("irq on rxf");
		read_status("status with rx irq");
		host_read(REG_DATA, b, "rx data under irq");
		m_rxf = 1'b0;
		check_irq("irq drops after data read");

		// tx interrupt follows txe
		host_write(REG_CTRL_STAT, 8'h20);
		m_rx_ie   = 1'b0;
		m_tx_ctrl = 2'b01;
		check_irq("tx irq with txe set");
		read_status("status with tx irq");
		b = 8'($random(seed));
		host_write(REG_DATA, b);
		m_txe = 1'b0;
		check_irq("tx irq drops on write");
		wait_tx_byte(got);
		check_eq(got, b, "tx frame byte under irq");
		repeat (SYM_CNT) @(posedge clk);
		m_txe = 1'b1;
		check_irq("tx irq back after frame");
		host_write(REG_CTRL_STAT, 8'h00);
		m_tx_ctrl = 2'b00;

		// master reset through the counter divide field
		b = 8'($random(seed));
		send_frame(b, 1'b1);
		m_rxf = 1'b1;
		m_err = 1'b1;
		read_status("status before master reset");
		host_write(REG_CTRL_STAT, 8'h03);
		m_rxf = 1'b0;
		m_err = 1'b0;
		read_status("status in master reset");
		host_write(REG_DATA, 8'h5a);          // dropped while held in reset
		for (i = 0; i < 2 * SYM_CNT; i++)
		begin
			@(negedge clk);
			check_eq({7'b0, tx}, 8'h01, "tx high in master reset");
		end
		read_status("status still reset");
		host_write(REG_CTRL_STAT, 8'h00);
		read_status("status after release");
		check_eq(8'(tx_q.size()), 8'h00, "no tx frame from reset write");

		// echo engine, host quiet
		@(posedge clk);
		echo_en <= 1'b1;
		for (i = 0; i < N_ECHO; i++)
		begin
			b = 8'($random(seed));
			sent_q.push_back(b);
			send_frame(b, 1'b0);
		end
		for (i = 0; i < N_ECHO; i++)
		begin
			wait_tx_byte(got);
			check_eq(got, sent_q[i], "echoed byte");
		end
		@(posedge clk);
		echo_en <= 1'b0;

		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: files.f
src/acia_pkg.sv
src/acia_rx.sv
src/acia_tx.sv
src/acia.sv
src/bus_arbiter.sv
src/echo_engine.sv
src/acia_subsys.sv
verification/tb_clock_gen.sv
verification/acia_properties.sv
verification/tb_acia_subsys.sv

// File: run.sh
#!/bin/sh
# build the ACIA subsystem testbench with Verilator, run it, grep the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_acia_subsys -o sim_acia \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_acia > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && exit 0 || exit 1
